// File: dv/stlb_properties.sv
// Bound checks on channel arbitration and response timing of the TLB top level.
// rsp_valid_o is set at the second edge after the grant edge, so in sampled
// values it shows three clocks after the grant.
`timescale 1ns/1ps

module stlb_properties #(
	parameter int CHANNELS = 4
) (
	input  logic                clk_g,
	input  logic                rst_i,
	input  logic [CHANNELS-1:0] ch_req_i,
	input  logic [CHANNELS-1:0] ch_grant_i,
	input  logic                rdy_i,
	input  logic                rsp_valid_i
);

	// Number of failed assertion attempts
	int unsigned fail_count = 0;

	grant_onehot: assert property (@(posedge clk_g) disable iff (rst_i)
		$onehot0(ch_grant_i)) else begin
		$error("more than one grant bit set");
		fail_count++;
	end

	grant_needs_req: assert property (@(posedge clk_g) disable iff (rst_i)
		(ch_grant_i & ~ch_req_i) == '0) else begin
		$error("grant to a channel without request");
		fail_count++;
	end

	grant_needs_rdy: assert property (@(posedge clk_g) disable iff (rst_i)
		!rdy_i |-> ch_grant_i == '0) else begin
		$error("grant issued while rdy_o is low");
		fail_count++;
	end

	grant_to_rsp: assert property (@(posedge clk_g) disable iff (rst_i)
		ch_grant_i != '0 |-> ##3 rsp_valid_i) else begin
		$error("no response two cycles after grant");
		fail_count++;
	end

endmodule

bind stlb_top stlb_properties #(
	.CHANNELS(CHANNELS)
) u_properties (
	.clk_g(clk_g),
	.rst_i(rst_i),
	.ch_req_i(ch_req_i),
	.ch_grant_i(ch_grant_o),
	.rdy_i(rdy_o),
	.rsp_valid_i(rsp_valid_o)
);

// File: dv/stlb_tb.sv
// Testbench for the shared TLB, with random traffic checked against a table model.
// Inputs change and outputs are checked on the falling edge. Lookups and maintenance
// never overlap, so the model table is static while a lookup is in flight.
`timescale 1ns/1ps

module stlb_tb
	import stlb_pkg::*, stlb_reg_pkg::*;
();

	localparam int CHANNELS = 4;
	localparam int ASSOC = 4;
	localparam int ENTRIES = 64;
	localparam int IDX_W = $clog2(ENTRIES);
	localparam int RDY_TMO = 400;
	localparam int GNT_TMO = 50;

	typedef struct packed {
		logic   hit;
		rwx_t   rwx;
		vaddr_t paddr;
	} result_t;

	typedef struct packed {
		logic [31:0] due;
		logic [1:0]  ch;
		result_t     res;
		vaddr_t      vaddr;
		asid_t       asid;
	} expect_t;

	logic                  clk_g = 1'b0;
	logic                  rst_i;
	logic [CHANNELS-1:0]   ch_req;
	vaddr_t [CHANNELS-1:0] ch_vaddr;
	asid_t [CHANNELS-1:0]  ch_asid;
	logic [CHANNELS-1:0]   ch_grant;
	logic                  rsp_valid;
	logic [1:0]            rsp_ch;
	logic                  rsp_hit;
	vaddr_t                rsp_paddr;
	rwx_t                  rsp_rwx;
	logic                  reg_wr;
	logic [REG_ADDR_W-1:0] reg_addr;
	logic [REG_DATA_W-1:0] reg_wdata;
	vaddr_t                miss_vaddr;
	asid_t                 miss_asid;
	logic                  rdy;

	// ==================================================
	// Reference model state
	// ==================================================
	logic   m_valid [ASSOC][ENTRIES];
	vpn_t   m_tag [ASSOC][ENTRIES];
	asid_t  m_asid [ASSOC][ENTRIES];
	vpn_t   m_ppn [ASSOC][ENTRIES];
	rwx_t   m_rwx [ASSOC][ENTRIES];
	logic   m_glob [ASSOC][ENTRIES];
	epoch_t m_epoch [ASSOC][ENTRIES];
	epoch_t cur_epoch;
	vaddr_t m_miss_vaddr;
	asid_t  m_miss_asid;

	logic [31:0]         rng = 32'hc3b2;
	int                  cyc;
	logic [CHANNELS-1:0] taken_grant = '0;
	int                  wait_cnt [CHANNELS];
	expect_t             exp_q [$];
	logic                last_hit;
	vpn_t                inst_vpn [$];
	asid_t               inst_asid [$];

	always #20 clk_g = ~clk_g;

	// Grant as the DUT takes it at the rising edge
	always @(posedge clk_g)
		taken_grant <= ch_grant;

	stlb_top #(
		.CHANNELS(CHANNELS),
		.ASSOC(ASSOC),
		.ENTRIES(ENTRIES)
	) UUT (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.ch_req_i(ch_req),
		.ch_vaddr_i(ch_vaddr),
		.ch_asid_i(ch_asid),
		.ch_grant_o(ch_grant),
		.rsp_valid_o(rsp_valid),
		.rsp_ch_o(rsp_ch),
		.rsp_hit_o(rsp_hit),
		.rsp_paddr_o(rsp_paddr),
		.rsp_rwx_o(rsp_rwx),
		.reg_wr_i(reg_wr),
		.reg_addr_i(reg_addr),
		.reg_wdata_i(reg_wdata),
		.miss_vaddr_o(miss_vaddr),
		.miss_asid_o(miss_asid),
		.rdy_o(rdy)
	);

	function automatic logic [31:0] xorshift32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic fail_value(input string msg);
		abort_run($sformatf("Fail at %0t: %s", $time, msg));
	endtask

	task automatic fail_other(input string msg);
		abort_run(msg);
	endtask

	// Top sixteen pages identity mapped in the last way at epoch 1
	task automatic model_reset();
		vpn_t vpn;
		for (int w = 0; w < ASSOC; w++)
			for (int i = 0; i < ENTRIES; i++)
				m_valid[w][i] = 1'b0;
		cur_epoch = 6'd1;
		m_miss_vaddr = '0;
		m_miss_asid = '0;
		for (int i = 0; i < 16; i++) begin
			vpn = 18'h3fff0 + 18'(i);
			m_valid[ASSOC-1][vpn[IDX_W-1:0]] = 1'b1;
			m_tag[ASSOC-1][vpn[IDX_W-1:0]] = vpn;
			m_asid[ASSOC-1][vpn[IDX_W-1:0]] = '0;
			m_ppn[ASSOC-1][vpn[IDX_W-1:0]] = vpn;
			m_rwx[ASSOC-1][vpn[IDX_W-1:0]] = 3'b111;
			m_glob[ASSOC-1][vpn[IDX_W-1:0]] = 1'b1;
			m_epoch[ASSOC-1][vpn[IDX_W-1:0]] = 6'd1;
		end
	endtask

	// Lowest way with a current, matching entry gives the result
	function automatic result_t predict(input vaddr_t va, input asid_t as);
		result_t res;
		vpn_t    vpn;
		int      idx;
		res = '0;
		vpn = va[VADDR_W-1:PAGE_OFS_W];
		idx = int'(vpn[IDX_W-1:0]);
		for (int w = 0; w < ASSOC; w++) begin
			if (!res.hit && m_valid[w][idx] && m_epoch[w][idx] == cur_epoch &&
					m_tag[w][idx] == vpn && (m_glob[w][idx] || m_asid[w][idx] == as)) begin
				res.hit = 1'b1;
				res.rwx = m_rwx[w][idx];
				res.paddr = {m_ppn[w][idx], va[PAGE_OFS_W-1:0]};
			end
		end
		return res;
	endfunction

	// ==================================================
	// Per-cycle grant bookkeeping and response checks
	// ==================================================
	task automatic next_cycle();
		expect_t e;
		@(negedge clk_g);
		cyc++;
		assert (UUT.u_properties.fail_count == 0)
			else fail_other("A bound assertion on the DUT failed");
		if (taken_grant != '0) begin
			for (int c = 0; c < CHANNELS; c++) begin
				if (taken_grant[c]) begin
					assert (ch_req[c])
						else fail_other($sformatf("Channel %0d was granted without a request", c));
					e.due = 32'(cyc + 2);
					e.ch = 2'(c);
					e.res = predict(ch_vaddr[c], ch_asid[c]);
					e.vaddr = ch_vaddr[c];
					e.asid = ch_asid[c];
					exp_q.push_back(e);
					ch_req[c] = 1'b0;
					wait_cnt[c] = 0;
				end else if (ch_req[c]) begin
					wait_cnt[c]++;
					assert (wait_cnt[c] < CHANNELS)
						else fail_other($sformatf("Channel %0d was passed over too often", c));
				end
			end
		end
		if (rsp_valid) begin
			assert (exp_q.size() != 0) else fail_other("Response with no lookup pending");
			e = exp_q.pop_front();
			assert (e.due == 32'(cyc))
				else fail_value($sformatf("response in cycle %0d, expected %0d", cyc, e.due));
			assert (rsp_ch == e.ch)
				else fail_value($sformatf("rsp_ch_o %0d, expected %0d", rsp_ch, e.ch));
			assert (rsp_hit == e.res.hit)
				else fail_value($sformatf("rsp_hit_o %0b for vaddr %h", rsp_hit, e.vaddr));
			assert (rsp_paddr == e.res.paddr)
				else fail_value($sformatf("rsp_paddr_o %h, expected %h", rsp_paddr, e.res.paddr));
			assert (rsp_rwx == e.res.rwx)
				else fail_value($sformatf("rsp_rwx_o %b, expected %b", rsp_rwx, e.res.rwx));
			if (!e.res.hit) begin
				m_miss_vaddr = e.vaddr;
				m_miss_asid = e.asid;
			end
			assert (miss_vaddr == m_miss_vaddr && miss_asid == m_miss_asid)
				else fail_value($sformatf("miss capture %h/%h, expected %h/%h", miss_vaddr,
					miss_asid, m_miss_vaddr, m_miss_asid));
			last_hit = rsp_hit;
		end else if (exp_q.size() != 0) begin
			assert (exp_q[0].due > 32'(cyc)) else fail_other("A granted lookup got no response");
		end
	endtask

	task automatic wait_ready();
		int t;
		t = 0;
		while (!rdy) begin
			next_cycle();
			t++;
			if (t > RDY_TMO)
				fail_other("Timeout while waiting for rdy_o");
		end
	endtask

	task automatic drain();
		int t;
		t = 0;
		while (exp_q.size() != 0) begin
			next_cycle();
			t++;
			if (t > GNT_TMO)
				fail_other("Timeout while waiting for a response");
		end
	endtask

	task automatic set_request(input int c, input vaddr_t va, input asid_t as);
		ch_req[c] = 1'b1;
		ch_vaddr[c] = va;
		ch_asid[c] = as;
		wait_cnt[c] = 0;
	endtask

	task automatic lookup(input int c, input vaddr_t va, input asid_t as);
		int t;
		set_request(c, va, as);
		t = 0;
		while (ch_req[c]) begin
			next_cycle();
			t++;
			if (t > GNT_TMO)
				fail_other("Timeout while waiting for a grant");
		end
		drain();
	endtask

	task automatic reg_write(input logic [REG_ADDR_W-1:0] a, input logic [31:0] d);
		reg_wr = 1'b1;
		reg_addr = a;
		reg_wdata = d;
		next_cycle();
		reg_wr = 1'b0;
	endtask

	task automatic install(input int way, input vpn_t vpn, input asid_t as, input vpn_t ppn,
			input rwx_t rwx, input logic glob);
		logic [31:0] pte;
		logic [31:0] vreg;
		logic [31:0] ctrl;
		int          idx;
		idx = int'(vpn[IDX_W-1:0]);
		pte = '0;
		pte[PTE_PPN_LSB +: VPN_W] = ppn;
		pte[PTE_RWX_LSB +: 3] = rwx;
		pte[PTE_GLOBAL_BIT] = glob;
		pte[PTE_VALID_BIT] = 1'b1;
		vreg = '0;
		vreg[VPN_VPN_LSB +: VPN_W] = vpn;
		vreg[VPN_ASID_LSB +: ASID_W] = as;
		ctrl = '0;
		ctrl[CTRL_INDEX_LSB +: IDX_W] = vpn[IDX_W-1:0];
		ctrl[CTRL_WAY_LSB +: 2] = 2'(way);
		ctrl[CTRL_INSTALL_BIT] = 1'b1;
		wait_ready();
		reg_write(REG_PTE, pte);
		reg_write(REG_VPN, vreg);
		reg_write(REG_CTRL, ctrl);
		assert (!rdy) else fail_other("rdy_o stayed high after an install command");
		m_valid[way][idx] = 1'b1;
		m_tag[way][idx] = vpn;
		m_asid[way][idx] = as;
		m_ppn[way][idx] = ppn;
		m_rwx[way][idx] = rwx;
		m_glob[way][idx] = glob;
		m_epoch[way][idx] = cur_epoch;
		wait_ready();
	endtask

	// New epoch skips 0 and stale entries drop out
	task automatic invalidate_all();
		wait_ready();
		reg_write(REG_CTRL, 32'(1) << CTRL_INVALL_BIT);
		assert (!rdy) else fail_other("rdy_o stayed high after an invalidate command");
		cur_epoch = (cur_epoch == 6'd63) ? 6'd1 : cur_epoch + 6'd1;
		for (int w = 0; w < ASSOC; w++)
			for (int i = 0; i < ENTRIES; i++)
				if (m_valid[w][i] && m_epoch[w][i] != cur_epoch)
					m_valid[w][i] = 1'b0;
		wait_ready();
	endtask

	// Mix of installed pages, reset-mapped pages and random addresses
	task automatic random_request(input int c);
		logic [31:0] r;
		vaddr_t      va;
		asid_t       as;
		int          k;
		r = xorshift32();
		va = xorshift32();
		as = r[27:16];
		case (r[1:0])
			2'd0, 2'd1: begin
				if (inst_vpn.size() != 0) begin
					k = int'(r[15:4]) % inst_vpn.size();
					va[VADDR_W-1:PAGE_OFS_W] = inst_vpn[k];
					if (!r[0])
						as = inst_asid[k];
				end
			end
			2'd2: va[31:18] = '1;
			default: ;
		endcase
		set_request(c, va, as);
	endtask

	task automatic random_traffic(input int n_req);
		int issued;
		int t;
		issued = 0;
		t = 0;
		while (issued < n_req || ch_req != '0 || exp_q.size() != 0) begin
			for (int c = 0; c < CHANNELS; c++) begin
				if (!ch_req[c] && issued < n_req && xorshift32() % 4 != 0) begin
					random_request(c);
					issued++;
				end
			end
			next_cycle();
			t++;
			if (t > n_req * 8 + 100)
				fail_other("Timeout while running random traffic");
		end
	endtask

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		logic [31:0] r;
		vpn_t        vpn;
		vpn_t        ppn;
		asid_t       as;
		rst_i = 1'b1;
		ch_req = '0;
		ch_vaddr = '0;
		ch_asid = '0;
		reg_wr = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		cyc = 0;
		last_hit = 1'b0;
		for (int c = 0; c < CHANNELS; c++)
			wait_cnt[c] = 0;
		model_reset();
		repeat (3) @(negedge clk_g);
		rst_i = 1'b0;
		assert (!rdy && ch_grant == '0 && !rsp_valid && miss_vaddr == '0 && miss_asid == '0)
			else fail_value("outputs not idle after reset");
		wait_ready();

		// Reset map
		for (int i = 0; i < 8; i++) begin
			r = xorshift32();
			lookup(i % CHANNELS, {14'h3fff, r[17:0]}, r[29:18]);
			assert (last_hit) else fail_value("reset-mapped page missed");
		end

		// Random installs each looked up with its own ASID
		for (int i = 0; i < 12; i++) begin
			r = xorshift32();
			vpn = r[17:0];
			as = r[29:18];
			r = xorshift32();
			ppn = r[31:14];
			install(int'(r[1:0]), vpn, as, ppn, r[4:2], r[5]);
			inst_vpn.push_back(vpn);
			inst_asid.push_back(as);
			lookup(int'(r[7:6]), {vpn, r[13:0]}, as);
			assert (last_hit) else fail_value("installed page missed");
		end

		// ASID mismatch on a non-global and a global entry
		r = xorshift32();
		install(0, r[17:0], 12'h0a1, r[31:14], 3'b110, 1'b0);
		inst_vpn.push_back(r[17:0]);
		inst_asid.push_back(12'h0a1);
		lookup(1, {r[17:0], 14'h0123}, 12'h0a2);
		assert (!last_hit) else fail_value("non-global entry hit with another ASID");
		r = xorshift32();
		install(1, r[17:0], 12'h0a1, r[31:14], 3'b101, 1'b1);
		inst_vpn.push_back(r[17:0]);
		inst_asid.push_back(12'h0a1);
		lookup(2, {r[17:0], 14'h0456}, 12'h0a2);
		assert (last_hit) else fail_value("global entry missed with another ASID");

		// After invalidate all the old entries and the reset map miss
		invalidate_all();
		for (int i = 0; i < inst_vpn.size(); i++) begin
			lookup(i % CHANNELS, {inst_vpn[i], 14'h0}, inst_asid[i]);
			assert (!last_hit) else fail_value("entry survived invalidate");
		end
		for (int i = 0; i < 4; i++) begin
			r = xorshift32();
			lookup(i, {14'h3fff, r[17:0]}, r[29:18]);
			assert (!last_hit) else fail_value("reset-mapped page survived invalidate");
		end
		inst_vpn.delete();
		inst_asid.delete();
		for (int i = 0; i < 8; i++) begin
			r = xorshift32();
			vpn = r[17:0];
			as = r[29:18];
			install(int'(r[31:30]), vpn, as, r[31:14], r[2:0], 1'b0);
			inst_vpn.push_back(vpn);
			inst_asid.push_back(as);
			lookup(i % CHANNELS, {vpn, r[13:0]}, as);
			assert (last_hit) else fail_value("install after invalidate missed");
		end

		// All channels at once
		random_traffic(300);

		// One more edge lets the last response timing property complete
		next_cycle();

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: project.f
rtl/stlb_pkg.sv
rtl/stlb_reg_pkg.sv
rtl/stlb_channel_arbiter.sv
rtl/stlb_entry_ram.sv
rtl/stlb_maint_ctrl.sv
rtl/stlb_lookup.sv
rtl/stlb_top.sv
dv/stlb_properties.sv
dv/stlb_tb.sv

// File: rtl/stlb_channel_arbiter.sv
// Round-robin arbiter in front of the lookup pipeline.
// A channel holds its request steady until granted. The grant is combinational
// and nothing is granted while the maintenance FSM is busy.
`timescale 1ns/1ps

module stlb_channel_arbiter
	import stlb_pkg::*;
#(
	parameter int CHANNELS = 4,
	localparam int CH_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
	input  logic                  clk_g,
	input  logic                  rst_i,
	input  logic                  busy_i,
	input  logic [CHANNELS-1:0]   ch_req_i,
	input  vaddr_t [CHANNELS-1:0] ch_vaddr_i,
	input  asid_t [CHANNELS-1:0]  ch_asid_i,
	output logic [CHANNELS-1:0]   ch_grant_o,
	output logic                  lk_valid_o,
	output logic [CH_W-1:0]       lk_ch_o,
	output vaddr_t                lk_vaddr_o,
	output asid_t                 lk_asid_o
);

	logic [CH_W-1:0] ptr_q;
	logic [CH_W-1:0] pick;
	logic            found;
	logic            take;

	// Search upward from the pointer, wrapping at CHANNELS
	always_comb begin
		int idx;
		found = 1'b0;
		pick = '0;
		for (int i = 0; i < CHANNELS; i++) begin
			idx = int'(ptr_q) + i;
			if (idx >= CHANNELS)
				idx = idx - CHANNELS;
			if (!found && ch_req_i[idx]) begin
				found = 1'b1;
				pick = idx[CH_W-1:0];
			end
		end
	end

	assign take = found & ~busy_i;

	always_comb begin
		ch_grant_o = '0;
		if (take)
			ch_grant_o[pick] = 1'b1;
	end

	// Pointer moves to one past the granted channel
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			ptr_q <= '0;
			lk_valid_o <= 1'b0;
		end else begin
			lk_valid_o <= take;
			if (take)
				ptr_q <= (pick == CH_W'(CHANNELS - 1)) ? '0 : pick + 1'b1;
		end
	end

	// Lookup command, held until the next grant
	always_ff @(posedge clk_g) begin
		if (take) begin
			lk_ch_o <= pick;
			lk_vaddr_o <= ch_vaddr_i[pick];
			lk_asid_o <= ch_asid_i[pick];
		end
	end

	if (CHANNELS < 2 || CHANNELS > MAX_CHANNELS) begin : g_bad_channels
		$error("stlb_channel_arbiter: CHANNELS must be 2 to %0d", MAX_CHANNELS);
	end

endmodule

// File: rtl/stlb_entry_ram.sv
// One way of TLB entry storage, as a dual-port synchronous RAM.
// Both ports read with one cycle of latency and only the maintenance port writes.
// Valid and epoch power up as zero, so no entry hits before it is written.
`timescale 1ns/1ps

module stlb_entry_ram
	import stlb_pkg::*;
#(
	parameter int ENTRIES = 64,
	localparam int IDX_W = $clog2(ENTRIES)
) (
	input  logic             clk_g,
	// Lookup port
	input  logic             lk_en_i,
	input  logic [IDX_W-1:0] lk_index_i,
	output vpn_t             lk_tag_o,
	output asid_t            lk_asid_o,
	output vpn_t             lk_ppn_o,
	output rwx_t             lk_rwx_o,
	output logic             lk_global_o,
	output logic             lk_valid_o,
	output epoch_t           lk_epoch_o,
	// Maintenance port
	input  logic             mt_we_i,
	input  logic [IDX_W-1:0] mt_index_i,
	input  vpn_t             mt_tag_i,
	input  asid_t            mt_asid_i,
	input  vpn_t             mt_ppn_i,
	input  rwx_t             mt_rwx_i,
	input  logic             mt_global_i,
	input  logic             mt_valid_i,
	input  epoch_t           mt_epoch_i,
	output logic             mt_valid_o,
	output epoch_t           mt_epoch_o
);

	vpn_t   tag_mem [ENTRIES];
	asid_t  asid_mem [ENTRIES];
	vpn_t   ppn_mem [ENTRIES];
	rwx_t   rwx_mem [ENTRIES];
	logic   global_mem [ENTRIES];
	logic   valid_mem [ENTRIES] = '{default: 1'b0};
	epoch_t epoch_mem [ENTRIES] = '{default: '0};

	// Maintenance write, plus read-back of valid and stamp for the sweep
	always_ff @(posedge clk_g) begin
		if (mt_we_i) begin
			tag_mem[mt_index_i] <= mt_tag_i;
			asid_mem[mt_index_i] <= mt_asid_i;
			ppn_mem[mt_index_i] <= mt_ppn_i;
			rwx_mem[mt_index_i] <= mt_rwx_i;
			global_mem[mt_index_i] <= mt_global_i;
			valid_mem[mt_index_i] <= mt_valid_i;
			epoch_mem[mt_index_i] <= mt_epoch_i;
		end
		mt_valid_o <= valid_mem[mt_index_i];
		mt_epoch_o <= epoch_mem[mt_index_i];
	end

	always_ff @(posedge clk_g) begin
		if (lk_en_i) begin
			lk_tag_o <= tag_mem[lk_index_i];
			lk_asid_o <= asid_mem[lk_index_i];
			lk_ppn_o <= ppn_mem[lk_index_i];
			lk_rwx_o <= rwx_mem[lk_index_i];
			lk_global_o <= global_mem[lk_index_i];
			lk_valid_o <= valid_mem[lk_index_i];
			lk_epoch_o <= epoch_mem[lk_index_i];
		end
	end

endmodule

// File: rtl/stlb_lookup.sv
// Tag compare and response stage of the lookup pipeline.
// The command is delayed one cycle to meet the RAM data and the result is
// registered one cycle later. The lowest matching way wins.
`timescale 1ns/1ps

module stlb_lookup
	import stlb_pkg::*;
#(
	parameter int CHANNELS = 4,
	parameter int ASSOC = 4,
	localparam int CH_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
) (
	input  logic               clk_g,
	input  logic               rst_i,
	input  logic               lk_valid_i,
	input  logic [CH_W-1:0]    lk_ch_i,
	input  vaddr_t             lk_vaddr_i,
	input  asid_t              lk_asid_i,
	input  epoch_t             epoch_i,
	// Entry RAM read data, one element per way
	input  vpn_t [ASSOC-1:0]   ram_tag_i,
	input  asid_t [ASSOC-1:0]  ram_asid_i,
	input  vpn_t [ASSOC-1:0]   ram_ppn_i,
	input  rwx_t [ASSOC-1:0]   ram_rwx_i,
	input  logic [ASSOC-1:0]   ram_global_i,
	input  logic [ASSOC-1:0]   ram_valid_i,
	input  epoch_t [ASSOC-1:0] ram_epoch_i,
	output logic               rsp_valid_o,
	output logic [CH_W-1:0]    rsp_ch_o,
	output logic               rsp_hit_o,
	output vaddr_t             rsp_paddr_o,
	output rwx_t               rsp_rwx_o,
	output vaddr_t             miss_vaddr_o,
	output asid_t              miss_asid_o
);

	logic             cmd_valid_q;
	logic [CH_W-1:0]  cmd_ch_q;
	vaddr_t           cmd_vaddr_q;
	asid_t            cmd_asid_q;
	vpn_t             cmd_vpn;
	logic [ASSOC-1:0] way_hit;
	logic             any_hit;
	vpn_t             hit_ppn;
	rwx_t             hit_rwx;

	// ==================================================
	// Command delay, aligned with RAM output
	// ==================================================
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i)
			cmd_valid_q <= 1'b0;
		else
			cmd_valid_q <= lk_valid_i;
	end

	always_ff @(posedge clk_g) begin
		if (lk_valid_i) begin
			cmd_ch_q <= lk_ch_i;
			cmd_vaddr_q <= lk_vaddr_i;
			cmd_asid_q <= lk_asid_i;
		end
	end

	assign cmd_vpn = cmd_vaddr_q[VADDR_W-1:PAGE_OFS_W];

	// ==================================================
	// Compare
	// ==================================================
	always_comb begin
		for (int w = 0; w < ASSOC; w++)
			way_hit[w] = ram_valid_i[w] && (ram_epoch_i[w] == epoch_i) &&
				(ram_tag_i[w] == cmd_vpn) &&
				(ram_global_i[w] || (ram_asid_i[w] == cmd_asid_q));
	end

	// Walk down so the lowest way is the last to assign
	always_comb begin
		hit_ppn = '0;
		hit_rwx = '0;
		for (int w = ASSOC - 1; w >= 0; w--) begin
			if (way_hit[w]) begin
				hit_ppn = ram_ppn_i[w];
				hit_rwx = ram_rwx_i[w];
			end
		end
	end

	assign any_hit = |way_hit;

	// Response strobe and miss capture
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			rsp_valid_o <= 1'b0;
			miss_vaddr_o <= '0;
			miss_asid_o <= '0;
		end else begin
			rsp_valid_o <= cmd_valid_q;
			if (cmd_valid_q && !any_hit) begin
				miss_vaddr_o <= cmd_vaddr_q;
				miss_asid_o <= cmd_asid_q;
			end
		end
	end

	always_ff @(posedge clk_g) begin
		if (cmd_valid_q) begin
			rsp_ch_o <= cmd_ch_q;
			rsp_hit_o <= any_hit;
			rsp_paddr_o <= any_hit ? {hit_ppn, cmd_vaddr_q[PAGE_OFS_W-1:0]} : '0;
			rsp_rwx_o <= hit_rwx;
		end
	end

endmodule

// File: rtl/stlb_maint_ctrl.sv
// Maintenance controller with the register file, the reset fill, installs and
// the invalidate sweep. Register writes are taken only while idle. A control
// write with both command bits set runs the invalidate and drops the install.
`timescale 1ns/1ps

module stlb_maint_ctrl
	import stlb_pkg::*, stlb_reg_pkg::*;
#(
	parameter int ASSOC = 4,
	parameter int ENTRIES = 64,
	localparam int IDX_W = $clog2(ENTRIES),
	localparam int WAY_W = (ASSOC > 1) ? $clog2(ASSOC) : 1
) (
	input  logic                  clk_g,
	input  logic                  rst_i,
	input  logic                  reg_wr_i,
	input  logic [REG_ADDR_W-1:0] reg_addr_i,
	input  logic [REG_DATA_W-1:0] reg_wdata_i,
	output logic                  busy_o,
	output epoch_t                epoch_o,
	output logic [ASSOC-1:0]      mt_we_o,
	output logic [IDX_W-1:0]      mt_index_o,
	output vpn_t                  mt_tag_o,
	output asid_t                 mt_asid_o,
	output vpn_t                  mt_ppn_o,
	output rwx_t                  mt_rwx_o,
	output logic                  mt_global_o,
	output logic                  mt_valid_o,
	output epoch_t                mt_epoch_o,
	input  logic [ASSOC-1:0]      mt_valid_i,
	input  epoch_t [ASSOC-1:0]    mt_epoch_i
);

	// Sixteen pages are mapped at reset
	localparam int FILL_W = 4;

	maint_state_t          state_q;
	logic [REG_DATA_W-1:0] pte_q;
	logic [REG_DATA_W-1:0] vpn_q;
	logic [REG_DATA_W-1:0] ctrl_q;
	logic [IDX_W-1:0]      cnt_q;
	epoch_t                epoch_q;
	logic                  reg_take;
	logic                  ctrl_wr;
	vpn_t                  fill_vpn;
	logic [WAY_W-1:0]      way_sel;

	assign reg_take = reg_wr_i && (state_q == ST_RUN);
	assign ctrl_wr = reg_take && (reg_addr_i == REG_CTRL);
	assign fill_vpn = {{(VPN_W - FILL_W){1'b1}}, cnt_q[FILL_W-1:0]};
	assign way_sel = ctrl_q[CTRL_WAY_LSB +: WAY_W];

	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			pte_q <= '0;
			vpn_q <= '0;
			ctrl_q <= '0;
		end else if (reg_take) begin
			case (reg_addr_i)
				REG_PTE: pte_q <= reg_wdata_i;
				REG_VPN: vpn_q <= reg_wdata_i;
				REG_CTRL: ctrl_q <= reg_wdata_i;
				default: ;
			endcase
		end
	end

	// ==================================================
	// Maintenance FSM
	// ==================================================
	always_ff @(posedge clk_g or posedge rst_i) begin
		if (rst_i) begin
			state_q <= ST_FILL;
			cnt_q <= '0;
			epoch_q <= epoch_t'(1);
		end else begin
			case (state_q)
				ST_FILL: begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q[FILL_W-1:0] == '1)
						state_q <= ST_RUN;
				end
				ST_RUN: begin
					if (ctrl_wr && reg_wdata_i[CTRL_INVALL_BIT]) begin
						// Wrap skips 0 so a zeroed stamp stays stale
						epoch_q <= (epoch_q == '1) ? epoch_t'(1) : epoch_q + 1'b1;
						cnt_q <= '0;
						state_q <= ST_SWEEP_RD;
					end else if (ctrl_wr && reg_wdata_i[CTRL_INSTALL_BIT]) begin
						state_q <= ST_INSTALL;
					end
				end
				ST_INSTALL: state_q <= ST_RUN;
				ST_SWEEP_RD: state_q <= ST_SWEEP_WR;
				ST_SWEEP_WR: begin
					cnt_q <= cnt_q + 1'b1;
					if (cnt_q == IDX_W'(ENTRIES - 1))
						state_q <= ST_RUN;
					else
						state_q <= ST_SWEEP_RD;
				end
				default: state_q <= ST_RUN;
			endcase
		end
	end

	// Maintenance port drive, install data unless a state overrides it
	always_comb begin
		mt_we_o = '0;
		mt_index_o = cnt_q;
		mt_tag_o = vpn_q[VPN_VPN_LSB +: VPN_W];
		mt_asid_o = vpn_q[VPN_ASID_LSB +: ASID_W];
		mt_ppn_o = pte_q[PTE_PPN_LSB +: VPN_W];
		mt_rwx_o = pte_q[PTE_RWX_LSB +: $bits(rwx_t)];
		mt_global_o = pte_q[PTE_GLOBAL_BIT];
		mt_valid_o = pte_q[PTE_VALID_BIT];
		mt_epoch_o = epoch_q;
		case (state_q)
			ST_FILL: begin
				// Identity map, global and fully permitted
				mt_we_o[ASSOC-1] = 1'b1;
				mt_index_o = fill_vpn[IDX_W-1:0];
				mt_tag_o = fill_vpn;
				mt_asid_o = '0;
				mt_ppn_o = fill_vpn;
				mt_rwx_o = '1;
				mt_global_o = 1'b1;
				mt_valid_o = 1'b1;
			end
			ST_INSTALL: begin
				mt_we_o[way_sel] = 1'b1;
				mt_index_o = ctrl_q[CTRL_INDEX_LSB +: IDX_W];
			end
			ST_SWEEP_WR: begin
				// Read data is from the index set up in ST_SWEEP_RD
				mt_valid_o = 1'b0;
				for (int w = 0; w < ASSOC; w++)
					mt_we_o[w] = mt_valid_i[w] && (mt_epoch_i[w] != epoch_q);
			end
			default: ;
		endcase
	end

	assign busy_o = (state_q != ST_RUN);
	assign epoch_o = epoch_q;

endmodule

// File: rtl/stlb_pkg.sv
// Translation widths shared by the TLB blocks.
// Pages are a fixed 16 KB, and virtual and physical addresses are both 32 bits
// wide, so one page number type serves both sides.
package stlb_pkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int VADDR_W = 32;
	localparam int PAGE_OFS_W = 14;
	localparam int VPN_W = VADDR_W - PAGE_OFS_W;
	localparam int ASID_W = 12;

	// Epoch 0 is never current, so a zeroed entry can never hit
	localparam int EPOCH_W = 6;

	// Largest channel count the arbiter is built for
	localparam int MAX_CHANNELS = 8;

	// ==================================================
	// Types
	// ==================================================
	typedef logic [VADDR_W-1:0] vaddr_t;
	typedef logic [VPN_W-1:0] vpn_t;
	typedef logic [ASID_W-1:0] asid_t;
	typedef logic [EPOCH_W-1:0] epoch_t;

	// Bit 2 read, bit 1 write, bit 0 execute
	typedef logic [2:0] rwx_t;

endpackage

// File: rtl/stlb_reg_pkg.sv
// Register map of the maintenance port.
// Registers are write-only, 32 bits wide, and selected by a word offset.
package stlb_reg_pkg;

	localparam int REG_ADDR_W = 2;
	localparam int REG_DATA_W = 32;

	// ==================================================
	// Offsets
	// ==================================================
	localparam logic [REG_ADDR_W-1:0] REG_PTE = 2'd0;
	localparam logic [REG_ADDR_W-1:0] REG_VPN = 2'd1;
	localparam logic [REG_ADDR_W-1:0] REG_CTRL = 2'd2;

	// Page table entry register
	localparam int PTE_PPN_LSB = 0;
	localparam int PTE_RWX_LSB = 18;
	localparam int PTE_GLOBAL_BIT = 21;
	localparam int PTE_VALID_BIT = 22;

	// Virtual page register
	localparam int VPN_VPN_LSB = 0;
	localparam int VPN_ASID_LSB = 18;

	// Control register, command bits start the FSM
	localparam int CTRL_INDEX_LSB = 0;
	localparam int CTRL_WAY_LSB = 8;
	localparam int CTRL_INSTALL_BIT = 16;
	localparam int CTRL_INVALL_BIT = 17;

	typedef enum logic [2:0] {
		ST_FILL,
		ST_RUN,
		ST_INSTALL,
		ST_SWEEP_RD,
		ST_SWEEP_WR
	} maint_state_t;

endpackage

// File: rtl/stlb_top.sv
// Shared set-associative TLB serving several requesting channels.
// A response follows two edges after the grant edge. Requests wait while
// rdy_o is low, and responses have no back-pressure.
`timescale 1ns/1ps

module stlb_top
	import stlb_pkg::*, stlb_reg_pkg::*;
#(
	parameter int CHANNELS = 4,
	parameter int ASSOC = 4,
	parameter int ENTRIES = 64,
	localparam int CH_W = (CHANNELS > 1) ? $clog2(CHANNELS) : 1,
	localparam int IDX_W = $clog2(ENTRIES)
) (
	input  logic                  clk_g,
	input  logic                  rst_i,
	// Channels
	input  logic [CHANNELS-1:0]   ch_req_i,
	input  vaddr_t [CHANNELS-1:0] ch_vaddr_i,
	input  asid_t [CHANNELS-1:0]  ch_asid_i,
	output logic [CHANNELS-1:0]   ch_grant_o,
	// Responses
	output logic                  rsp_valid_o,
	output logic [CH_W-1:0]       rsp_ch_o,
	output logic                  rsp_hit_o,
	output vaddr_t                rsp_paddr_o,
	output rwx_t                  rsp_rwx_o,
	// Registers
	input  logic                  reg_wr_i,
	input  logic [REG_ADDR_W-1:0] reg_addr_i,
	input  logic [REG_DATA_W-1:0] reg_wdata_i,
	output vaddr_t                miss_vaddr_o,
	output asid_t                 miss_asid_o,
	output logic                  rdy_o
);

	logic               busy;
	epoch_t             epoch;

	// Lookup command
	logic               lk_valid;
	logic [CH_W-1:0]    lk_ch;
	vaddr_t             lk_vaddr;
	asid_t              lk_asid;
	logic [IDX_W-1:0]   lk_index;

	// Per-way RAM read data
	vpn_t [ASSOC-1:0]   ram_tag;
	asid_t [ASSOC-1:0]  ram_asid;
	vpn_t [ASSOC-1:0]   ram_ppn;
	rwx_t [ASSOC-1:0]   ram_rwx;
	logic [ASSOC-1:0]   ram_global;
	logic [ASSOC-1:0]   ram_valid;
	epoch_t [ASSOC-1:0] ram_epoch;

	// Maintenance port
	logic [ASSOC-1:0]   mt_we;
	logic [IDX_W-1:0]   mt_index;
	vpn_t               mt_tag;
	asid_t              mt_asid;
	vpn_t               mt_ppn;
	rwx_t               mt_rwx;
	logic               mt_global;
	logic               mt_valid;
	epoch_t             mt_epoch;
	logic [ASSOC-1:0]   mt_valid_rd;
	epoch_t [ASSOC-1:0] mt_epoch_rd;

	// Set index is the low page number bits
	assign lk_index = lk_vaddr[PAGE_OFS_W +: IDX_W];
	assign rdy_o = ~busy;

	stlb_channel_arbiter #(
		.CHANNELS(CHANNELS)
	) u_arbiter (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.busy_i(busy),
		.ch_req_i(ch_req_i),
		.ch_vaddr_i(ch_vaddr_i),
		.ch_asid_i(ch_asid_i),
		.ch_grant_o(ch_grant_o),
		.lk_valid_o(lk_valid),
		.lk_ch_o(lk_ch),
		.lk_vaddr_o(lk_vaddr),
		.lk_asid_o(lk_asid)
	);

	stlb_maint_ctrl #(
		.ASSOC(ASSOC),
		.ENTRIES(ENTRIES)
	) u_maint (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.reg_wr_i(reg_wr_i),
		.reg_addr_i(reg_addr_i),
		.reg_wdata_i(reg_wdata_i),
		.busy_o(busy),
		.epoch_o(epoch),
		.mt_we_o(mt_we),
		.mt_index_o(mt_index),
		.mt_tag_o(mt_tag),
		.mt_asid_o(mt_asid),
		.mt_ppn_o(mt_ppn),
		.mt_rwx_o(mt_rwx),
		.mt_global_o(mt_global),
		.mt_valid_o(mt_valid),
		.mt_epoch_o(mt_epoch),
		.mt_valid_i(mt_valid_rd),
		.mt_epoch_i(mt_epoch_rd)
	);

	// ==================================================
	// Entry storage, one RAM per way
	// ==================================================
	for (genvar w = 0; w < ASSOC; w++) begin : g_way
		stlb_entry_ram #(
			.ENTRIES(ENTRIES)
		) u_ram (
			.clk_g(clk_g),
			.lk_en_i(lk_valid),
			.lk_index_i(lk_index),
			.lk_tag_o(ram_tag[w]),
			.lk_asid_o(ram_asid[w]),
			.lk_ppn_o(ram_ppn[w]),
			.lk_rwx_o(ram_rwx[w]),
			.lk_global_o(ram_global[w]),
			.lk_valid_o(ram_valid[w]),
			.lk_epoch_o(ram_epoch[w]),
			.mt_we_i(mt_we[w]),
			.mt_index_i(mt_index),
			.mt_tag_i(mt_tag),
			.mt_asid_i(mt_asid),
			.mt_ppn_i(mt_ppn),
			.mt_rwx_i(mt_rwx),
			.mt_global_i(mt_global),
			.mt_valid_i(mt_valid),
			.mt_epoch_i(mt_epoch),
			.mt_valid_o(mt_valid_rd[w]),
			.mt_epoch_o(mt_epoch_rd[w])
		);
	end

	stlb_lookup #(
		.CHANNELS(CHANNELS),
		.ASSOC(ASSOC)
	) u_lookup (
		.clk_g(clk_g),
		.rst_i(rst_i),
		.lk_valid_i(lk_valid),
		.lk_ch_i(lk_ch),
		.lk_vaddr_i(lk_vaddr),
		.lk_asid_i(lk_asid),
		.epoch_i(epoch),
		.ram_tag_i(ram_tag),
		.ram_asid_i(ram_asid),
		.ram_ppn_i(ram_ppn),
		.ram_rwx_i(ram_rwx),
		.ram_global_i(ram_global),
		.ram_valid_i(ram_valid),
		.ram_epoch_i(ram_epoch),
		.rsp_valid_o(rsp_valid_o),
		.rsp_ch_o(rsp_ch_o),
		.rsp_hit_o(rsp_hit_o),
		.rsp_paddr_o(rsp_paddr_o),
		.rsp_rwx_o(rsp_rwx_o),
		.miss_vaddr_o(miss_vaddr_o),
		.miss_asid_o(miss_asid_o)
	);

endmodule
